// File: hw/bk_mem_pkg.sv
// BK0011M/BK0010 physical memory map constants
// CPU bus and memory request structs, system page register layout
// RAM page code decode
`default_nettype none

package bk_mem_pkg;

	localparam int phys_aw = 20; // Physical byte address width

	// RAM pages, 16 KB each
	localparam logic [phys_aw:0] ram_p0 = 21'h00000;
	localparam logic [phys_aw:0] ram_p1 = 21'h04000;
	localparam logic [phys_aw:0] ram_p2 = 21'h08000;
	localparam logic [phys_aw:0] ram_p3 = 21'h0C000;
	localparam logic [phys_aw:0] ram_p4 = 21'h10000;
	localparam logic [phys_aw:0] ram_p5 = 21'h14000; // Screen 0 in BK0010 mode
	localparam logic [phys_aw:0] ram_p6 = 21'h18000;
	localparam logic [phys_aw:0] ram_p7 = 21'h1C000;
	localparam logic [phys_aw:0] ram_ext = 21'h20000; // First address past main RAM

	// Read-only region
	localparam logic [phys_aw:0] rom_start = 21'hE0000;
	localparam logic [phys_aw:0] rom_p10 = 21'hE0000; // BASIC11
	localparam logic [phys_aw:0] rom_p11 = 21'hE4000;
	localparam logic [phys_aw:0] rom_p12 = 21'hE8000;
	localparam logic [phys_aw:0] rom_p13 = 21'hEC000;
	localparam logic [phys_aw:0] bios11 = 21'hF0000;
	localparam logic [phys_aw:0] bios10 = 21'hF4000;
	localparam logic [phys_aw:0] basic10 = 21'hF6000;
	localparam logic [phys_aw:0] mstd_rom = 21'hFE000;
	localparam logic [phys_aw:0] no_mem = 21'h100000; // Nothing mapped here

	// CPU bus address limits
	localparam logic [15:0] io_base = 16'o177600; // Registers start here
	localparam logic [15:0] legacy_top = 16'o177000; // Writable RAM ends here

	localparam int mem_words = 131072; // 64K RAM words plus 64K ROM words

	// System page register, written at 177716 with bit 11 set
	typedef struct packed {
		logic       unused15;
		logic [2:0] win1_page; // RAM page at 040000
		logic       enable;
		logic [2:0] win2_page; // RAM page at 100000
		logic [2:0] unused7_5;
		logic       rom_sel4; // ROM page 13
		logic       rom_sel3; // ROM page 12
		logic       unused2;
		logic       rom_sel1; // ROM page 11
		logic       rom_sel0; // ROM page 10
	} page_reg_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] din;
		logic [1:0]  wtbt; // Byte enables, bit 0 is the low byte
		logic        we;
		logic        sync;
	} bus_req_t;

	typedef struct packed {
		logic [phys_aw-1:0] addr;
		logic [15:0]        din;
		logic [1:0]         wtbt;
		logic               we;
	} mem_req_t;

	// Page codes are scrambled in hardware
	function automatic logic [phys_aw:0] page_to_phys(input logic [2:0] code);
		case (code)
			3'b110: return ram_p0;
			3'b000: return ram_p1;
			3'b010: return ram_p2;
			3'b011: return ram_p3;
			3'b100: return ram_p4;
			3'b001: return ram_p5;
			3'b111: return ram_p6;
			default: return ram_p7;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: hw/page_mapper.sv
// System page register with its write edge detector
// CPU bus address to physical address translation, BK0011M and BK0010 maps
// Access validity and legacy RAM classification
`default_nettype none

module page_mapper (
	input  wire logic                 clk_sys,
	input  wire logic                 arst_n,
	input  wire bk_mem_pkg::bus_req_t bus,
	input  wire logic                 bus_stb,
	input  wire logic                 sysreg_sel,
	input  wire logic                 bk0010,
	output bk_mem_pkg::mem_req_t      mem,
	output logic                      access_valid,
	output logic                      legacy_ram
);

	localparam int maw = bk_mem_pkg::phys_aw + 1; // Room for the no_mem marker

	bk_mem_pkg::page_reg_t page_reg;
	bk_mem_pkg::page_reg_t new_reg;
	logic sysreg_write;
	logic sysreg_write_d;
	logic [3:0] rom_sel;
	logic [maw-1:0] win2_base;
	logic [maw-1:0] base11;
	logic [maw-1:0] base10;
	logic [maw-1:0] map11;
	logic [maw-1:0] map10;
	logic [maw-1:0] phys;

	assign sysreg_write = sysreg_sel & bus_stb & bus.we;
	assign new_reg = bus.din;

	// Loads once per write strobe, high byte must be written
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sysreg_write_d <= 1'b0;
			page_reg <= '0;
		end else begin
			sysreg_write_d <= sysreg_write;
			if (sysreg_write & ~sysreg_write_d & new_reg.enable & bus.wtbt[1])
				page_reg <= new_reg;
		end
	end

	assign rom_sel = {page_reg.rom_sel4, page_reg.rom_sel3, page_reg.rom_sel1, page_reg.rom_sel0};

	// Window 2 is ROM when any select flag is set, lowest flag wins
	always_comb begin
		if (rom_sel[0])
			win2_base = bk_mem_pkg::rom_p10;
		else if (rom_sel[1])
			win2_base = bk_mem_pkg::rom_p11;
		else if (rom_sel[2])
			win2_base = bk_mem_pkg::rom_p12;
		else if (rom_sel[3])
			win2_base = bk_mem_pkg::rom_p13;
		else
			win2_base = bk_mem_pkg::page_to_phys(page_reg.win2_page);
	end

	// BK0011M, 16 KB windows
	always_comb begin
		case (bus.addr[15:13])
			3'b000, 3'b001: base11 = bk_mem_pkg::ram_p0;
			3'b010, 3'b011: base11 = bk_mem_pkg::page_to_phys(page_reg.win1_page);
			3'b100, 3'b101: base11 = win2_base;
			3'b110: base11 = bk_mem_pkg::bios11;
			default: base11 = bk_mem_pkg::mstd_rom; // Bit 13 is already set in the base
		endcase
	end

	// BK0010, fixed 8 KB windows
	always_comb begin
		case (bus.addr[15:13])
			3'b000: base10 = bk_mem_pkg::ram_p0;
			3'b001: base10 = bk_mem_pkg::ram_p0 + 21'h02000;
			3'b010: base10 = bk_mem_pkg::ram_p5; // Screen
			3'b011: base10 = bk_mem_pkg::ram_p5 + 21'h02000;
			3'b100: base10 = bk_mem_pkg::bios10;
			3'b101: base10 = bk_mem_pkg::basic10;
			3'b110: base10 = bk_mem_pkg::basic10 + 21'h02000;
			default: base10 = bk_mem_pkg::basic10 + 21'h04000;
		endcase
	end

	assign map11 = base11 | maw'(bus.addr[13:0]);
	assign map10 = base10 | maw'(bus.addr[12:0]);
	assign phys = bk0010 ? map10 : map11;

	// ROM is read-only, registers are never memory
	assign access_valid = (bus.addr < bk_mem_pkg::io_base) && (phys != bk_mem_pkg::no_mem)
		&& (!bus.we || ((bus.addr < bk_mem_pkg::legacy_top) && (phys < bk_mem_pkg::rom_start)));

	assign legacy_ram = phys < bk_mem_pkg::ram_ext; // Shared with the video controller

	always_comb begin
		mem.addr = phys[bk_mem_pkg::phys_aw-1:0];
		mem.din = bus.din;
		mem.wtbt = bus.wtbt;
		mem.we = bus.we;
	end

endmodule

`default_nettype wire

// File: hw/vp037_timer.sv
// VP1-037 video controller phase counter
// Produces the slot in which a legacy CPU access may reach RAM
`default_nettype none

module vp037_timer (
	input  wire logic clk_sys,
	input  wire logic arst_n,
	input  wire logic ce_6mp,
	input  wire logic ce_6mn,
	output logic      slot
);

	logic [2:0] phase; // Eight 6 MHz ticks per memory cycle
	logic quad; // Phase bit 1 delayed by one tick
	logic slot_phase;

	// Quad high with phase 4 is the only CPU window
	assign slot_phase = quad & ~phase[1] & phase[2];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			phase <= 3'd0;
			quad <= 1'b0;
		end else if (ce_6mn) begin
			phase <= phase + 3'd1;
			if (!phase[0])
				quad <= phase[1]; // Sampled on even phases only
		end
	end

	// One clk_sys wide, on the positive half of the 6 MHz clock
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			slot <= 1'b0;
		else
			slot <= ce_6mp & slot_phase;
	end

endmodule

`default_nettype wire

// File: hw/bus_cycle_fsm.sv
// Bus cycle FSM for the CPU memory interface
// Waits for a VP1-037 slot on legacy RAM without turbo
// Issues the one-cycle memory strobe and holds ack until the bus strobe drops
`default_nettype none

module bus_cycle_fsm (
	input  wire logic clk_sys,
	input  wire logic arst_n,
	input  wire logic bus_stb,
	input  wire logic sync,
	input  wire logic access_valid,
	input  wire logic legacy_ram,
	input  wire logic turbo,
	input  wire logic slot,
	output logic      mem_strobe,
	output logic      bus_ack
);

	typedef enum logic [2:0] {
		idle,
		wait_slot,
		access,
		data,
		acked
	} state_t;

	state_t state;
	state_t state_nx;
	logic stb_d;
	logic start;

	assign start = bus_stb & ~stb_d & sync; // New request on the strobe edge

	always_comb begin
		state_nx = state;
		case (state)
			idle: begin
				// Invalid requests are left unanswered
				if (start && access_valid)
					state_nx = (legacy_ram && !turbo) ? wait_slot : access;
			end
			wait_slot: begin
				if (!bus_stb)
					state_nx = idle; // CPU gave up
				else if (slot)
					state_nx = access;
			end
			access: state_nx = data; // Memory samples the request
			data: state_nx = acked; // Read word is registered
			acked: begin
				if (!bus_stb)
					state_nx = idle;
			end
			default: state_nx = idle;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			stb_d <= 1'b0;
		end else begin
			state <= state_nx;
			stb_d <= bus_stb;
		end
	end

	assign mem_strobe = (state == access);
	assign bus_ack = (state == acked);

endmodule

`default_nettype wire

// File: hw/phys_memory.sv
// Physical word memory, 64K RAM words and 64K ROM words
// Byte-enabled bus writes, full-word loader writes, registered reads
`default_nettype none

module phys_memory (
	input  wire logic                              clk_sys,
	input  wire bk_mem_pkg::mem_req_t              mem,
	input  wire logic                              mem_strobe,
	input  wire logic                              load_we,
	input  wire logic [bk_mem_pkg::phys_aw-1:0]    load_addr,
	input  wire logic [15:0]                       load_din,
	output logic [15:0]                            rd_data
);

	localparam int iw = $clog2(bk_mem_pkg::mem_words);

	logic [1:0][7:0] ram [bk_mem_pkg::mem_words];
	logic bus_wr;
	logic [iw-1:0] wr_idx;
	logic [iw-1:0] rd_idx;
	logic [15:0] wr_data;
	logic [1:0] wr_be;

	// RAM fills the lower half, ROM region the upper half
	function automatic logic [iw-1:0] word_index(input logic [bk_mem_pkg::phys_aw-1:0] addr);
		logic [bk_mem_pkg::phys_aw-1:0] off;
		off = addr - bk_mem_pkg::rom_start[bk_mem_pkg::phys_aw-1:0];
		if ({1'b0, addr} >= bk_mem_pkg::rom_start)
			return {1'b1, off[16:1]};
		return {1'b0, addr[16:1]};
	endfunction

	assign bus_wr = mem_strobe & mem.we & ({1'b0, mem.addr} < bk_mem_pkg::rom_start);

	// Loader only runs while the CPU bus is quiet
	assign wr_idx = load_we ? word_index(load_addr) : word_index(mem.addr);
	assign wr_data = load_we ? load_din : mem.din;
	assign wr_be = load_we ? 2'b11 : (bus_wr ? mem.wtbt : 2'b00);
	assign rd_idx = word_index(mem.addr);

	always_ff @(posedge clk_sys) begin
		if (wr_be[0])
			ram[wr_idx][0] <= wr_data[7:0];
		if (wr_be[1])
			ram[wr_idx][1] <= wr_data[15:8];
		if (mem_strobe && !mem.we)
			rd_data <= ram[rd_idx]; // Held until the next read
	end

endmodule

`default_nettype wire

// File: hw/bk_memory_top.sv
// BK0011M/BK0010 memory subsystem top level
// Page mapper, VP1-037 timer, bus cycle FSM and physical memory
`default_nettype none

module bk_memory_top (
	input  wire logic                           clk_sys,
	input  wire logic                           arst_n,
	input  wire bk_mem_pkg::bus_req_t           bus,
	input  wire logic                           bus_stb,
	input  wire logic                           sysreg_sel,
	input  wire logic                           bk0010,
	input  wire logic                           turbo,
	input  wire logic                           ce_6mp,
	input  wire logic                           ce_6mn,
	input  wire logic                           load_we,
	input  wire logic [bk_mem_pkg::phys_aw-1:0] load_addr,
	input  wire logic [15:0]                    load_din,
	output logic [15:0]                         bus_dout,
	output logic                                bus_ack
);

	bk_mem_pkg::mem_req_t mem;
	logic access_valid;
	logic legacy_ram;
	logic slot;
	logic mem_strobe;
	logic [15:0] rd_data;

	page_mapper u_page_mapper (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.bus          (bus),
		.bus_stb      (bus_stb),
		.sysreg_sel   (sysreg_sel),
		.bk0010       (bk0010),
		.mem          (mem),
		.access_valid (access_valid),
		.legacy_ram   (legacy_ram)
	);

	vp037_timer u_vp037_timer (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ce_6mp  (ce_6mp),
		.ce_6mn  (ce_6mn),
		.slot    (slot)
	);

	bus_cycle_fsm u_bus_cycle_fsm (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.bus_stb      (bus_stb),
		.sync         (bus.sync),
		.access_valid (access_valid),
		.legacy_ram   (legacy_ram),
		.turbo        (turbo),
		.slot         (slot),
		.mem_strobe   (mem_strobe),
		.bus_ack      (bus_ack)
	);

	phys_memory u_phys_memory (
		.clk_sys    (clk_sys),
		.mem        (mem),
		.mem_strobe (mem_strobe),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.load_din   (load_din),
		.rd_data    (rd_data)
	);

	assign bus_dout = bus_ack ? rd_data : 16'h0000; // Bus is wired-OR, idle low

endmodule

`default_nettype wire

// File: bench/bk_memory_props.sv
// Concurrent assertions on the bus cycle FSM handshake
// Bound into every bus_cycle_fsm instance
`default_nettype none

module bk_memory_props (
	input wire logic clk_sys,
	input wire logic arst_n,
	input wire logic bus_stb,
	input wire logic mem_strobe,
	input wire logic bus_ack
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// Ack is held for as long as the CPU keeps its strobe
	ack_held: assert property (@(posedge clk_sys) disable iff (!arst_n)
		bus_ack && bus_stb |=> bus_ack)
		else begin
			$error("bus_ack dropped while bus_stb was still high");
			fail_count++;
		end

	strobe_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mem_strobe |=> !mem_strobe)
		else begin
			$error("mem_strobe lasted longer than one cycle");
			fail_count++;
		end

	// Every ack is preceded by a memory access and an active bus strobe
	ack_after_access: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(bus_ack) |-> bus_stb && $past(mem_strobe, 2))
		else begin
			$error("bus_ack rose without a bus strobe and memory access");
			fail_count++;
		end

endmodule

bind bus_cycle_fsm bk_memory_props u_props (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.bus_stb    (bus_stb),
	.mem_strobe (mem_strobe),
	.bus_ack    (bus_ack)
);

`default_nettype wire

// File: bench/bk_memory_checker.sv
// Reference model of the BK memory map, page register and word store
// Checks acks and read data, prints per-test and total counts
`default_nettype none

module bk_memory_checker (
	input  wire logic                           clk_sys,
	input  wire logic                           arst_n,
	input  wire bk_mem_pkg::bus_req_t           bus,
	input  wire logic                           bus_stb,
	input  wire logic                           sysreg_sel,
	input  wire logic                           bk0010,
	input  wire logic                           bus_ack,
	input  wire logic [15:0]                    bus_dout,
	input  wire logic                           load_we,
	input  wire logic [bk_mem_pkg::phys_aw-1:0] load_addr,
	input  wire logic [15:0]                    load_din,
	input  wire logic [31:0]                    test_num,
	input  wire logic                           test_end,
	input  wire logic                           all_done,
	output int                                  error_count
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [15:0] store [int]; // Word index to contents
	logic [15:0] preg; // Page register model
	logic wr_d;
	logic prev_stb;
	logic in_req;
	logic acked;
	logic exp_valid;
	logic [20:0] req_phys;
	bk_mem_pkg::bus_req_t req;
	int wait_cnt;
	int checks;
	int t_checks;
	int t_errs;

	function automatic logic [20:0] ram_page(input logic [2:0] code);
		case (code)
			3'b110: return 21'h00000;
			3'b000: return 21'h04000;
			3'b010: return 21'h08000;
			3'b011: return 21'h0C000;
			3'b100: return 21'h10000;
			3'b001: return 21'h14000;
			3'b111: return 21'h18000;
			default: return 21'h1C000;
		endcase
	endfunction

	function automatic logic [20:0] map_phys(input logic [15:0] a, input logic bk10,
		input logic [15:0] pr);
		logic [20:0] base;
		if (bk10) begin
			case (a[15:13])
				3'd0: base = 21'h00000;
				3'd1: base = 21'h02000; // Alias inside page 0
				3'd2: base = 21'h14000;
				3'd3: base = 21'h16000;
				3'd4: base = 21'hF4000;
				3'd5: base = 21'hF6000;
				3'd6: base = 21'hF8000;
				default: base = 21'hFA000;
			endcase
			return base + 21'(a[12:0]);
		end
		case (a[15:14])
			2'd0: base = 21'h00000;
			2'd1: base = ram_page(pr[14:12]);
			2'd2: begin
				if (pr[0]) base = 21'hE0000;
				else if (pr[1]) base = 21'hE4000;
				else if (pr[3]) base = 21'hE8000;
				else if (pr[4]) base = 21'hEC000;
				else base = ram_page(pr[10:8]);
			end
			default: base = a[13] ? 21'hFC000 : 21'hF0000; // Monitor sits at FE000
		endcase
		return base + 21'(a[13:0]);
	endfunction

	function automatic int word_idx(input logic [20:0] p);
		if (p < 21'h20000)
			return int'(p >> 1);
		return 65536 + int'((p - 21'hE0000) >> 1);
	endfunction

	task automatic count_error();
		error_count++;
		t_errs++;
	endtask

	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			preg = '0;
			wr_d = 1'b0;
			prev_stb = 1'b0;
			in_req = 1'b0;
			acked = 1'b0;
		end else begin
			// Data bus is idle low outside the ack
			if (!bus_ack && bus_dout !== 16'h0000) begin
				$display("mismatch at %0t: bus_dout %h without bus_ack, expected 0000",
					$time, bus_dout);
				count_error();
			end
			if (load_we)
				store[word_idx({1'b0, load_addr})] = load_din;
			if (bus_stb && !prev_stb && bus.sync) begin
				in_req = 1'b1;
				acked = 1'b0;
				wait_cnt = 0;
				req = bus;
				req_phys = map_phys(bus.addr, bk0010, preg);
				exp_valid = (bus.addr < 16'o177600) &&
					(!bus.we || (bus.addr < 16'o177000 && req_phys < 21'hE0000));
			end else if (in_req) begin
				if (bus_ack && !acked) begin
					acked = 1'b1;
					if (!exp_valid) begin
						$display("error at %0t: access to %h was acked but must be refused",
							$time, req.addr);
						count_error();
					end else if (!req.we) begin
						checks++;
						t_checks++;
						if (store.exists(word_idx(req_phys)) &&
							bus_dout !== store[word_idx(req_phys)]) begin
							$display("mismatch at %0t: read %h (phys %h) got %h expected %h",
								$time, req.addr, req_phys, bus_dout, store[word_idx(req_phys)]);
							count_error();
						end
					end else begin
						if (req.wtbt[0])
							store[word_idx(req_phys)][7:0] = req.din[7:0];
						if (req.wtbt[1])
							store[word_idx(req_phys)][15:8] = req.din[15:8];
					end
				end else if (!acked && bus_stb) begin
					wait_cnt++;
					if (wait_cnt == 41 && exp_valid) begin
						$display("error at %0t: no ack within 40 cycles for address %h",
							$time, req.addr);
						count_error();
					end
				end
				if (!bus_stb)
					in_req = 1'b0;
			end
			prev_stb = bus_stb;
			// Page register follows the write strobe edge
			if (sysreg_sel && bus_stb && bus.we && !wr_d && bus.din[11] && bus.wtbt[1])
				preg = bus.din;
			wr_d = sysreg_sel && bus_stb && bus.we;
		end
	end

	always @(posedge clk_sys) begin
		if (test_end) begin
			$display("test %0d done: %0d reads checked, %0d errors", test_num, t_checks,
				t_errs);
			t_checks = 0;
			t_errs = 0;
		end
		if (all_done)
			$display("total: %0d reads checked, %0d errors", checks, error_count);
	end

	initial begin
		error_count = 0;
		checks = 0;
		t_checks = 0;
		t_errs = 0;
	end

endmodule

`default_nettype wire

// File: bench/tb_bk_memory.sv
// Testbench top for the BK memory subsystem
// Clock, reset, 6 MHz enables, ROM and RAM fill, random bus tests, watchdog
`default_nettype none

module tb_bk_memory;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_tests = 5;
	localparam int acc_per_test = 120;
	localparam int fill_cycles = 2 * 65536 + 100;
	localparam int limit = fill_cycles + n_tests * acc_per_test * 50 + 200;
	localparam logic [15:0] sysreg_addr = 16'o177716;

	logic clk_sys;
	logic arst_n;
	bk_mem_pkg::bus_req_t bus;
	logic bus_stb;
	logic sysreg_sel;
	logic bk0010;
	logic turbo;
	logic ce_6mp;
	logic ce_6mn;
	logic load_we;
	logic [19:0] load_addr;
	logic [15:0] load_din;
	logic [15:0] bus_dout;
	logic bus_ack;
	logic [1:0] ce_cnt;
	int test_num;
	logic test_end;
	logic all_done;
	int error_count;

	bk_memory_top UUT (
		.clk_sys(clk_sys), .arst_n(arst_n), .bus(bus), .bus_stb(bus_stb),
		.sysreg_sel(sysreg_sel), .bk0010(bk0010), .turbo(turbo),
		.ce_6mp(ce_6mp), .ce_6mn(ce_6mn), .load_we(load_we), .load_addr(load_addr),
		.load_din(load_din), .bus_dout(bus_dout), .bus_ack(bus_ack)
	);

	bk_memory_checker u_checker (
		.clk_sys(clk_sys), .arst_n(arst_n), .bus(bus), .bus_stb(bus_stb),
		.sysreg_sel(sysreg_sel), .bk0010(bk0010), .bus_ack(bus_ack), .bus_dout(bus_dout),
		.load_we(load_we), .load_addr(load_addr), .load_din(load_din),
		.test_num(test_num), .test_end(test_end), .all_done(all_done),
		.error_count(error_count)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ce_6mn every 4 cycles, ce_6mp half a period later
	always @(posedge clk_sys) begin
		ce_cnt <= ce_cnt + 2'd1;
		ce_6mn <= (ce_cnt == 2'd3);
		ce_6mp <= (ce_cnt == 2'd1);
	end

	initial begin
		repeat (limit) @(posedge clk_sys);
		$display("error: watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	// Pattern over all address bits so aliases are told apart
	function automatic logic [15:0] fill_word(input logic [19:0] a);
		return a[16:1] ^ {a[19:17], a[19:17], a[19:17], 7'h2B};
	endfunction

	task automatic cpu_access(input logic [15:0] addr, input logic we, input logic [15:0] din,
		input logic [1:0] wtbt, input logic sel);
		int n;
		@(posedge clk_sys);
		bus <= '{addr: addr, din: din, wtbt: wtbt, we: we, sync: 1'b1};
		sysreg_sel <= sel;
		bus_stb <= 1'b1;
		n = 0;
		@(posedge clk_sys);
		while (!bus_ack && n < 45) begin
			@(posedge clk_sys);
			n++;
		end
		bus_stb <= 1'b0;
		sysreg_sel <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic cpu_read(input logic [15:0] addr);
		cpu_access(addr & 16'hFFFE, 1'b0, 16'h0000, 2'b11, 1'b0);
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [15:0] din,
		input logic [1:0] wtbt);
		cpu_access(addr & 16'hFFFE, 1'b1, din, wtbt, 1'b0);
	endtask

	task automatic page_write(input logic [15:0] val, input logic [1:0] wtbt);
		cpu_access(sysreg_addr, 1'b1, val, wtbt, 1'b1);
	endtask

	task automatic finish_test();
		@(posedge clk_sys);
		test_end <= 1'b1;
		@(posedge clk_sys);
		test_end <= 1'b0;
		test_num <= test_num + 1;
	endtask

	task automatic fill_memory();
		for (int i = 0; i < 131072; i++) begin
			@(posedge clk_sys);
			load_we <= 1'b1;
			load_addr <= (i < 65536) ? 20'(i * 2) : 20'h E0000 + 20'((i - 65536) * 2);
			load_din <= fill_word((i < 65536) ? 20'(i * 2) : 20'hE0000 + 20'((i - 65536) * 2));
		end
		@(posedge clk_sys);
		load_we <= 1'b0;
	endtask

	task automatic ram_pairs(input int count);
		logic [15:0] a;
		logic [1:0] be;
		for (int k = 0; k < count; k++) begin
			a = 16'($urandom_range(0, 16'h7FFE));
			be = 2'($urandom_range(1, 3)); // Single bytes and whole words
			cpu_write(a, 16'($urandom), be);
			cpu_read(a);
		end
	endtask

	initial begin
		logic [15:0] pv;
		void'($urandom(3));
		arst_n = 1'b0;
		bus = '0;
		bus_stb = 1'b0;
		sysreg_sel = 1'b0;
		bk0010 = 1'b0;
		turbo = 1'b1;
		ce_6mp = 1'b0;
		ce_6mn = 1'b0;
		ce_cnt = 2'd0;
		load_we = 1'b0;
		load_addr = '0;
		load_din = '0;
		test_num = 1;
		test_end = 1'b0;
		all_done = 1'b0;
		repeat (16) @(posedge clk_sys);
		arst_n <= 1'b1;
		fill_memory();

		// 1: RAM windows under random page settings
		for (int i = 0; i < 12; i++) begin
			page_write(16'($urandom) & 16'h7F00 | 16'h0800, 2'b11);
			ram_pairs(4);
		end
		finish_test();

		// 2: ROM reads and refused ROM writes
		for (int i = 0; i < 10; i++) begin
			pv = 16'h0800 | (16'h1 << {1'b0, 3'($urandom_range(0, 4))});
			page_write(pv, 2'b11);
			cpu_read(16'h8000 + 16'($urandom_range(0, 16'h3FFE)));
			cpu_read(16'hC000 + 16'($urandom_range(0, 16'h1FFE)));
			cpu_read(16'hE000 + 16'($urandom_range(0, 16'h1EFE)));
			pv = 16'hC000 + 16'($urandom_range(0, 16'h1FFE));
			cpu_write(pv, 16'($urandom), 2'b11);
			cpu_read(pv);
			pv = 16'h8000 + 16'($urandom_range(0, 16'h3FFE));
			cpu_write(pv, 16'($urandom), 2'b11);
			cpu_read(pv);
		end
		finish_test();

		// 3: BK0010 fixed map
		bk0010 <= 1'b1;
		for (int i = 0; i < 50; i++) begin
			pv = 16'($urandom_range(0, 16'hFEFE));
			if (pv < 16'h8000 && $urandom_range(0, 1) == 1)
				cpu_write(pv, 16'($urandom), 2'($urandom_range(1, 3)));
			cpu_read(pv);
		end
		finish_test();

		// 4: legacy timing without turbo
		bk0010 <= 1'b0;
		turbo <= 1'b0;
		for (int i = 0; i < 8; i++) begin
			page_write(16'($urandom) & 16'h7700 | 16'h0800, 2'b11);
			ram_pairs(3);
			cpu_read(16'hC000 + 16'($urandom_range(0, 16'h1FFE)));
		end
		finish_test();

		// 5: register space and rejected page writes
		turbo <= 1'b1;
		page_write(16'h3800, 2'b11);
		for (int i = 0; i < 8; i++) begin
			pv = 16'hFF80 + 16'($urandom_range(0, 16'h7E));
			cpu_read(pv);
			cpu_write(pv, 16'($urandom), 2'b11);
			page_write(16'($urandom) & 16'h77FF, 2'b11); // Enable bit clear
			page_write(16'($urandom) | 16'h0800, 2'b01); // High byte not written
			cpu_read(16'h4000 + 16'($urandom_range(0, 16'h3FFE)));
		end
		finish_test();

		@(posedge clk_sys);
		all_done <= 1'b1;
		@(posedge clk_sys);
		all_done <= 1'b0;
		repeat (2) @(posedge clk_sys);
		if (error_count == 0 && UUT.u_bus_cycle_fsm.u_props.fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
hw/bk_mem_pkg.sv
hw/page_mapper.sv
hw/vp037_timer.sv
hw/bus_cycle_fsm.sv
hw/phys_memory.sv
hw/bk_memory_top.sv
bench/bk_memory_props.sv
bench/bk_memory_checker.sv
bench/tb_bk_memory.sv

// File: run_sim.sh
#!/bin/sh
# Builds the BK memory testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f src.f \
	--top-module tb_bk_memory \
	-o sim_bk_memory

./obj_dir/sim_bk_memory 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

if ! grep -q "TEST PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
